// File: sim.f
src/snake_pkg.sv
src/tick_gen.sv
src/bcd_counter.sv
src/snake_engine.sv
src/apple_place.sv
src/display_scan.sv
src/snake_top.sv
dv/snake_tb.sv

// File: Makefile
SIM_DIR = obj_dir

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -Wno-fatal --top-module snake_tb \
		--Mdir $(SIM_DIR) -o snake_sim -f sim.f
	./$(SIM_DIR)/snake_sim

lint:
	verilator --lint-only --timing -Wall --top-module snake_top -f sim.f

clean:
	rm -rf $(SIM_DIR)

// File: dv/snake_tb.sv
module snake_tb import snake_pkg::*; ();

	logic clk;
	logic reset;
	dir_keys_t keys;
	logic [7:0] led_segout;
	logic [2:0] led_scanout;
	logic [7:0] matrix_segout_r;
	logic [7:0] matrix_segout_g;
	logic [7:0] matrix_scanout;

	// rows and digits as scanned so far in the current frame
	logic [63:0] row_red;
	logic [63:0] row_green;
	logic [7:0] cap_digits [6];
	logic [7:0] seen_phases;
	int last_phase;

	// last complete frame
	logic [63:0] frame_r;
	logic [63:0] frame_g;
	logic [7:0] frame_digits [6];
	event frame_done;

	// reference model, head at index 0
	int snake [$];
	dir_t model_dir;
	dir_t model_req;
	int apple_cell;
	bit apple_known;
	bit game_over;
	int score_count;
	int seconds;
	int checked_frames;
	int steps_done;
	logic [15:0] lfsr_state;

	snake_top dut0 (
		.clk             (clk),
		.reset           (reset),
		.keys            (keys),
		.led_segout      (led_segout),
		.led_scanout     (led_scanout),
		.matrix_segout_r (matrix_segout_r),
		.matrix_segout_g (matrix_segout_g),
		.matrix_scanout  (matrix_scanout)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic abort_run(string reason);
		$display("SOME TESTS FAILED");
		$fatal(1, "%s", reason);
	endtask

	task automatic compare_value(string name, logic [63:0] expected, logic [63:0] actual);
		if (actual !== expected) begin
			$display("FAILED %s expected %h actual %h", name, expected, actual);
			abort_run("a checked value did not match");
		end
	endtask

	// row 0 column 0 sits at the top bit
	function automatic logic [63:0] cell_bit(int c);
		return 64'd1 << (63 - c);
	endfunction

	function automatic logic [63:0] snake_map();
		logic [63:0] m;
		m = '0;
		foreach (snake[i]) begin
			m |= cell_bit(snake[i]);
		end
		return m;
	endfunction

	function automatic int marked_cell(logic [63:0] m);
		int c;
		c = -1;
		for (int i = 0; i < 64; i++) begin
			if (m[i]) begin
				c = 63 - i;
			end
		end
		return c;
	endfunction

	// segment a in the top bit
	function automatic logic [7:0] seg_code(int d);
		case (d)
			0: return 8'hfc;
			1: return 8'h60;
			2: return 8'hda;
			3: return 8'hf2;
			4: return 8'h66;
			5: return 8'hb6;
			6: return 8'hbe;
			7: return 8'he0;
			8: return 8'hfe;
			default: return 8'hf6;
		endcase
	endfunction

	function automatic logic [7:0] expected_digit(int value, int place);
		int d;
		bit lit;
		d = (place == 2) ? (value / 100) % 10 : (place == 1) ? (value / 10) % 10 : value % 10;
		lit = (place == 0) || (place == 1 && value >= 10) || (place == 2 && value >= 100);
		return lit ? seg_code(d) : 8'h00;
	endfunction

	// timer on digits 0 to 2, score on 3 to 5, hundreds first
	function automatic logic [7:0] expected_seg(int p);
		return (p < 3) ? expected_digit(seconds, 2 - p) : expected_digit(score_count, 5 - p);
	endfunction

	function automatic dir_t opposite_of(dir_t d);
		case (d)
			dir_up:   return dir_down;
			dir_down: return dir_up;
			dir_left: return dir_right;
			default:  return dir_left;
		endcase
	endfunction

	function automatic dir_t steer_dir(int head, int target, dir_t cur);
		int dr;
		int dc;
		dir_t want;
		dir_t side;
		dr = (target / 8 - head / 8 + 8) % 8;
		dc = (target % 8 - head % 8 + 8) % 8;
		if (dr != 0) begin
			want = (dr <= 4) ? dir_down : dir_up;
			side = (dc <= 4) ? dir_right : dir_left;
		end else begin
			want = (dc <= 4) ? dir_right : dir_left;
			side = dir_down;
		end
		return (want == opposite_of(cur)) ? side : want;
	endfunction

	// taps 16,14,13,11
	function automatic logic [15:0] lfsr_step(logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic int random_bits(int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = (v << 1) | lfsr_state[0];
		end
		return v;
	endfunction

	// one game step of the model
	task automatic advance_model(output bit ate);
		int row;
		int col;
		int next_cell;
		bit grow;
		ate = 1'b0;
		if (model_req != opposite_of(model_dir)) begin
			model_dir = model_req;
		end
		row = snake[0] / 8;
		col = snake[0] % 8;
		case (model_dir)
			dir_up:   row = (row + 7) % 8;
			dir_down: row = (row + 1) % 8;
			dir_left: col = (col + 7) % 8;
			default:  col = (col + 1) % 8;
		endcase
		next_cell = row * 8 + col;
		// the tail cell is vacated in the same step
		for (int i = 0; i < snake.size() - 1; i++) begin
			if (snake[i] == next_cell) begin
				game_over = 1'b1;
			end
		end
		if (!game_over) begin
			ate = (next_cell == apple_cell);
			grow = ate && (snake.size() < 63);
			snake.push_front(next_cell);
			if (!grow) begin
				void'(snake.pop_back());
			end
			if (ate) begin
				score_count++;
				apple_known = 1'b0;
			end
		end
	endtask

	task automatic wait_checked(int target);
		int cycles;
		cycles = 0;
		while (checked_frames < target) begin
			@(negedge clk);
			cycles++;
			if (cycles > 3000) begin
				abort_run($sformatf("frame %0d was not seen within 3000 cycles", target));
			end
		end
	endtask

	task automatic press_key(dir_t d);
		@(negedge clk);
		case (d)
			dir_up:   keys.up = 1'b1;
			dir_down: keys.down = 1'b1;
			dir_left: keys.left = 1'b1;
			default:  keys.right = 1'b1;
		endcase
		model_req = d;
		@(negedge clk);
		keys = '0;
	endtask

	// key goes in halfway through a step, then wait for the step frame
	task automatic run_step(dir_t d, bit press);
		wait_checked(16 * steps_done + 9);
		if (press) begin
			press_key(d);
		end
		wait_checked(16 * (steps_done + 1) + 1);
		steps_done++;
	endtask

	always @(negedge clk) begin : capture_frames
		int phase;
		if (reset && matrix_scanout != 8'h00) begin
			compare_value("row select one-hot", 1, $onehot(matrix_scanout));
			phase = 0;
			for (int i = 0; i < 8; i++) begin
				if (matrix_scanout[i]) begin
					phase = i;
				end
			end
			if (phase == 0 && last_phase == 7) begin
				if (seen_phases == 8'hff) begin
					frame_r = row_red;
					frame_g = row_green;
					frame_digits = cap_digits;
					-> frame_done;
				end
				seen_phases = '0;
			end
			row_red[63 - 8 * phase -: 8] = matrix_segout_r;
			row_green[63 - 8 * phase -: 8] = matrix_segout_g;
			if (phase < 6) begin
				cap_digits[phase] = led_segout;
			end
			compare_value("digit select", (phase < 6) ? phase : 0, led_scanout);
			seen_phases[phase] = 1'b1;
			last_phase = phase;
		end
	end

	initial begin : compare_frames
		int n;
		int extra_count;
		logic [63:0] extra;
		logic [63:0] prev_green;
		logic [63:0] head_bit;
		bit step_due;
		bit fresh_apple;
		n = 0;
		prev_green = '0;
		forever begin
			@(frame_done);
			// 32 frames per second, 16 per step
			if (n > 0 && n % 32 == 0 && !game_over) begin
				seconds++;
			end
			step_due = (n > 0) && (n % 16 == 0) && !game_over;
			fresh_apple = 1'b0;
			if (step_due) begin
				advance_model(fresh_apple);
			end
			if (n > 0) begin
				compare_value("step boundary", step_due, frame_g != prev_green);
			end
			if (game_over) begin
				compare_value("green after collision", 0, frame_g);
				compare_value("body in red", snake_map(), frame_r);
			end else begin
				compare_value("green map", snake_map(), frame_g);
				head_bit = cell_bit(snake[0]);
				extra = frame_r & ~frame_g;
				extra_count = $countones(extra);
				if (!apple_known) begin
					compare_value("at most one new apple", 1, extra_count <= 1);
					// the new apple may land after its row was scanned
					if (extra_count == 1 || !fresh_apple) begin
						compare_value("new apple pixel count", 1, extra_count);
						apple_cell = marked_cell(extra);
						apple_known = 1'b1;
					end
				end
				if (apple_known) begin
					compare_value("red map", head_bit | cell_bit(apple_cell), frame_r);
				end else begin
					compare_value("red map", head_bit, frame_r);
				end
			end
			for (int p = 0; p < 6; p++) begin
				compare_value($sformatf("digit %0d", p), expected_seg(p), frame_digits[p]);
			end
			prev_green = frame_g;
			n++;
			checked_frames = n;
		end
	end

	initial begin : run_tests
		int guard;
		dir_t start_dir;
		dir_t side_dir;
		keys = '0;
		reset = 1'b0;
		lfsr_state = 16'd85;
		seen_phases = '0;
		last_phase = 0;
		checked_frames = 0;
		steps_done = 0;
		snake = '{0};
		model_dir = dir_down;
		model_req = dir_down;
		apple_cell = 3 * 8 + 4;
		apple_known = 1'b1;
		game_over = 1'b0;
		score_count = 0;
		seconds = 0;
		repeat (16) begin
			@(negedge clk);
			compare_value("outputs dark in reset", 0,
				{led_segout, matrix_segout_r, matrix_segout_g, matrix_scanout});
		end
		reset = 1'b1;

		// straight down column 0, wrapping past row 7
		repeat (12) begin
			run_step(dir_down, 1'b0);
		end
		// reversal while moving down
		run_step(dir_up, 1'b1);
		repeat (10) begin
			run_step(dir_t'(random_bits(2)), 1'b1);
		end

		guard = 0;
		while (snake.size() < 5 && !game_over) begin
			if (guard == 150) begin
				abort_run("the snake did not grow to five cells");
			end
			wait_checked(16 * steps_done + 9);
			run_step(steer_dir(snake[0], apple_cell, model_dir), 1'b1);
			guard++;
		end

		// tight u-turn back into the neck
		guard = 0;
		while (!game_over) begin
			if (guard == 4) begin
				abort_run("the snake never ran into its own body");
			end
			start_dir = model_dir;
			side_dir = (start_dir == dir_up || start_dir == dir_down) ? dir_right : dir_down;
			run_step(side_dir, 1'b1);
			run_step(opposite_of(start_dir), 1'b1);
			run_step(opposite_of(side_dir), 1'b1);
			guard++;
		end

		// display stays frozen, keys do nothing
		run_step(dir_left, 1'b1);
		repeat (3) begin
			run_step(dir_up, 1'b0);
		end
		compare_value("timer reached ten seconds", 1, seconds >= 10);
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

// File: src/snake_top.sv
module snake_top import snake_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  dir_keys_t keys,
	output logic [7:0] led_segout,
	output logic [2:0] led_scanout,
	output logic [7:0] matrix_segout_r,
	output logic [7:0] matrix_segout_g,
	output logic [7:0] matrix_scanout
);

	logic step_tick;
	logic sec_tick;
	logic [2:0] scan_phase;
	logic apple_req_valid;
	logic apple_req_ready;
	logic apple_rsp_valid;
	cell_t apple_rsp_cell;
	logic score_inc;
	logic timer_en;
	logic timer_inc;
	board_t board;
	bcd3_t timer;
	bcd3_t score;

	// seconds only count while the game runs
	assign timer_inc = sec_tick && timer_en;

	tick_gen tick0 (
		.clk        (clk),
		.reset      (reset),
		.step_tick  (step_tick),
		.sec_tick   (sec_tick),
		.scan_phase (scan_phase)
	);

	snake_engine engine0 (
		.clk             (clk),
		.reset           (reset),
		.step_tick       (step_tick),
		.keys            (keys),
		.apple_req_valid (apple_req_valid),
		.apple_req_ready (apple_req_ready),
		.apple_rsp_valid (apple_rsp_valid),
		.apple_rsp_cell  (apple_rsp_cell),
		.score_inc       (score_inc),
		.timer_en        (timer_en),
		.board           (board)
	);

	apple_place apple0 (
		.clk       (clk),
		.reset     (reset),
		.occupancy (board.occupancy),
		.req_valid (apple_req_valid),
		.req_ready (apple_req_ready),
		.rsp_valid (apple_rsp_valid),
		.rsp_cell  (apple_rsp_cell)
	);

	bcd_counter timer0 (
		.clk   (clk),
		.reset (reset),
		.inc   (timer_inc),
		.value (timer)
	);

	bcd_counter score0 (
		.clk   (clk),
		.reset (reset),
		.inc   (score_inc),
		.value (score)
	);

	display_scan disp0 (
		.clk             (clk),
		.reset           (reset),
		.scan_phase      (scan_phase),
		.board           (board),
		.timer           (timer),
		.score           (score),
		.led_segout      (led_segout),
		.led_scanout     (led_scanout),
		.matrix_segout_r (matrix_segout_r),
		.matrix_segout_g (matrix_segout_g),
		.matrix_scanout  (matrix_scanout)
	);

endmodule

// File: src/display_scan.sv
module display_scan import snake_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic [2:0] scan_phase,
	input  board_t     board,
	input  bcd3_t      timer,
	input  bcd3_t      score,
	output logic [7:0] led_segout,
	output logic [2:0] led_scanout,
	output logic [7:0] matrix_segout_r,
	output logic [7:0] matrix_segout_g,
	output logic [7:0] matrix_scanout
);

	logic [board_dim-1:0] map_row;
	logic [board_dim-1:0] head_mark;
	logic [board_dim-1:0] apple_mark;
	logic [board_dim-1:0] red_next;
	logic [board_dim-1:0] green_next;
	logic [7:0] seg_next;

	// pixel of cell c if it sits in the scanned row
	function automatic logic [board_dim-1:0] row_mark(cell_t c, logic [2:0] row);
		logic [board_dim-1:0] mark;
		mark = '0;
		if (c.rc.row == row) begin
			mark = {1'b1, {(board_dim-1){1'b0}}} >> c.rc.col;
		end
		return mark;
	endfunction

	// place 2 is hundreds; leading zeros go dark, units always lit
	function automatic logic [7:0] digit_seg(bcd3_t v, int place);
		logic [3:0] d;
		logic lit;
		d = v[4*place +: 4];
		lit = (place == 0) || ((v >> (4 * place)) != '0);
		return lit ? seg_patterns[d] : 8'h00;
	endfunction

	assign map_row = board.occupancy[cell_count - 1 - board_dim * scan_phase -: board_dim];
	assign head_mark = row_mark(board.head, scan_phase);
	assign apple_mark = row_mark(board.apple, scan_phase);

	always_comb begin
		if (board.stage == stage_playing) begin
			green_next = map_row;
			red_next = head_mark | apple_mark;
		end else begin
			// game over, whole body in red
			green_next = '0;
			red_next = map_row;
		end
	end

	always_comb begin
		case (scan_phase)
			3'd0:    seg_next = digit_seg(timer, 2);
			3'd1:    seg_next = digit_seg(timer, 1);
			3'd2:    seg_next = digit_seg(timer, 0);
			3'd3:    seg_next = digit_seg(score, 2);
			3'd4:    seg_next = digit_seg(score, 1);
			3'd5:    seg_next = digit_seg(score, 0);
			default: seg_next = 8'h00;
		endcase
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			led_segout <= '0;
			led_scanout <= '0;
			matrix_segout_r <= '0;
			matrix_segout_g <= '0;
			matrix_scanout <= '0;
		end else begin
			led_segout <= seg_next;
			// phases 6 and 7 park on digit 0 with segments dark
			led_scanout <= (scan_phase < 3'd6) ? scan_phase : 3'd0;
			matrix_segout_r <= red_next;
			matrix_segout_g <= green_next;
			matrix_scanout <= 8'b1 << scan_phase;
		end
	end

	// the head pixel always sits on the drawn map
	a_head_on_map: assert property (@(posedge clk) disable iff (!reset)
		board.occupancy[cell_count - 1 - board.head.idx]);

endmodule

// File: src/apple_place.sv
module apple_place import snake_pkg::*; (
	input  logic                  clk,
	input  logic                  reset,
	input  logic [cell_count-1:0] occupancy,
	input  logic                  req_valid,
	output logic                  req_ready,
	output logic                  rsp_valid,
	output cell_t                 rsp_cell
);

	logic [7:0] lfsr;
	logic busy;
	cell_t cand;
	// map as it was when the request was taken
	logic [cell_count-1:0] occ_snap;
	logic cand_free;
	logic accept;

	assign req_ready = !busy;
	assign accept = req_valid && req_ready;
	assign cand_free = !occ_snap[cell_count - 1 - cand.idx];

	// taps 8,6,5,4
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			lfsr <= lfsr_seed;
		end else begin
			lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
		end
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			busy <= 1'b0;
			rsp_valid <= 1'b0;
		end else begin
			rsp_valid <= 1'b0;
			if (accept) begin
				busy <= 1'b1;
			end else if (rsp_valid) begin
				// idle again once the response has gone out
				busy <= 1'b0;
			end else if (busy && cand_free) begin
				rsp_valid <= 1'b1;
			end
		end
	end

	// one candidate per cycle, stride walk modulo 64
	always_ff @(posedge clk) begin
		if (accept) begin
			cand.idx <= lfsr[5:0];
			occ_snap <= occupancy;
		end else if (busy) begin
			if (cand_free) begin
				rsp_cell <= cand;
			end else begin
				cand.idx <= cand.idx + apple_stride;
			end
		end
	end

	a_rsp_not_idle: assert property (@(posedge clk) disable iff (!reset)
		rsp_valid |-> !req_ready);

endmodule

// File: src/snake_engine.sv
module snake_engine import snake_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  logic      step_tick,
	input  dir_keys_t keys,
	output logic      apple_req_valid,
	input  logic      apple_req_ready,
	input  logic      apple_rsp_valid,
	input  cell_t     apple_rsp_cell,
	output logic      score_inc,
	output logic      timer_en,
	output board_t    board
);

	cell_t head;
	// body behind the head, trail[1] is the neck
	cell_t trail [1:cell_count-1];
	logic [$clog2(cell_count):0] length;
	logic [cell_count-1:0] occupancy;
	dir_t dir;
	dir_t req_dir;
	dir_t next_dir;
	cell_t apple;
	stage_t stage;
	// high from the eating step until the new apple arrives
	logic apple_busy;

	cell_t tail;
	cell_t next_head;
	logic [cell_count-1:0] occ_cleared;
	logic [cell_count-1:0] head_bit;
	logic advance;
	logic hit;
	logic eat;
	logic grow;

	function automatic logic [cell_count-1:0] cell_bit(cell_t c);
		return {1'b1, {(cell_count-1){1'b0}}} >> c.idx;
	endfunction

	// up/down and left/right share the upper bit
	function automatic logic is_reverse(dir_t a, dir_t b);
		return (a[1] == b[1]) && (a[0] != b[0]);
	endfunction

	assign advance = step_tick && (stage == stage_playing) && !apple_busy;
	assign next_dir = is_reverse(req_dir, dir) ? dir : req_dir;
	assign tail = (length == 1) ? head : trail[6'(length - 1'b1)];

	// three-bit row and column arithmetic wraps at the edges
	always_comb begin
		next_head = head;
		case (next_dir)
			dir_up:    next_head.rc.row = head.rc.row - 3'd1;
			dir_down:  next_head.rc.row = head.rc.row + 3'd1;
			dir_left:  next_head.rc.col = head.rc.col - 3'd1;
			default:   next_head.rc.col = head.rc.col + 3'd1;
		endcase
	end

	// the tail cell leaves in the same step, so it is free for the head
	assign occ_cleared = occupancy & ~cell_bit(tail);
	assign head_bit = cell_bit(next_head);
	assign hit = |(occ_cleared & head_bit);
	assign eat = (next_head == apple);
	// growth stops at 63 cells, leaving one cell for the apple
	assign grow = eat && (length < cell_count - 1);

	// last key seen, up has priority
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			req_dir <= dir_down;
		end else if (keys.up) begin
			req_dir <= dir_up;
		end else if (keys.down) begin
			req_dir <= dir_down;
		end else if (keys.left) begin
			req_dir <= dir_left;
		end else if (keys.right) begin
			req_dir <= dir_right;
		end
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			head <= '0;
			length <= 1;
			occupancy <= cell_bit('0);
			dir <= dir_down;
			stage <= stage_playing;
			apple <= apple_start;
			apple_busy <= 1'b0;
			apple_req_valid <= 1'b0;
			score_inc <= 1'b0;
		end else begin
			score_inc <= 1'b0;
			if (apple_req_valid && apple_req_ready) begin
				apple_req_valid <= 1'b0;
			end
			if (apple_rsp_valid) begin
				apple <= apple_rsp_cell;
				apple_busy <= 1'b0;
			end
			if (advance) begin
				dir <= next_dir;
				if (hit) begin
					stage <= stage_over;
				end else begin
					head <= next_head;
					occupancy <= (grow ? occupancy : occ_cleared) | head_bit;
					if (grow) begin
						length <= length + 1'b1;
					end
					if (eat) begin
						score_inc <= 1'b1;
						apple_busy <= 1'b1;
						apple_req_valid <= 1'b1;
					end
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (advance && !hit) begin
			trail[1] <= head;
			for (int i = 2; i < cell_count; i++) begin
				trail[i] <= trail[i-1];
			end
		end
	end

	assign timer_en = (stage == stage_playing);
	assign board = '{occupancy: occupancy, head: head, apple: apple, stage: stage};

	// the placer must never drop the apple onto the body
	a_apple_free: assert property (@(posedge clk) disable iff (!reset)
		(stage == stage_playing && !apple_busy) |-> !(|(occupancy & cell_bit(apple))));

endmodule

// File: src/bcd_counter.sv
module bcd_counter import snake_pkg::*; (
	input  logic  clk,
	input  logic  reset,
	input  logic  inc,
	output bcd3_t value
);

	bcd3_t value_next;

	// decimal ripple carry, 999 wraps to 000
	always_comb begin
		logic carry;
		carry = 1'b1;
		value_next = value;
		for (int d = 0; d < 3; d++) begin
			if (carry) begin
				if (value[4*d +: 4] == 4'd9) begin
					value_next[4*d +: 4] = 4'd0;
				end else begin
					value_next[4*d +: 4] = value[4*d +: 4] + 4'd1;
					carry = 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			value <= '0;
		end else if (inc) begin
			value <= value_next;
		end
	end

endmodule

// File: src/tick_gen.sv
module tick_gen import snake_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	output logic       step_tick,
	output logic       sec_tick,
	output logic [2:0] scan_phase
);

	localparam int step_w = $clog2(step_cycles);
	localparam int sec_w = $clog2(second_cycles);
	localparam int scan_w = $clog2(scan_cycles * scan_phases);

	logic [step_w-1:0] step_cnt;
	logic [sec_w-1:0] sec_cnt;
	logic [scan_w-1:0] scan_cnt;

	assign step_tick = (step_cnt == step_w'(step_cycles - 1));
	assign sec_tick = (sec_cnt == sec_w'(second_cycles - 1));
	// upper bits count the phases
	assign scan_phase = scan_cnt[scan_w-1 -: 3];

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			step_cnt <= '0;
			sec_cnt <= '0;
			scan_cnt <= '0;
		end else begin
			step_cnt <= step_tick ? '0 : step_cnt + 1'b1;
			sec_cnt <= sec_tick ? '0 : sec_cnt + 1'b1;
			// wraps once per full frame
			scan_cnt <= scan_cnt + 1'b1;
		end
	end

endmodule

// File: src/snake_pkg.sv
package snake_pkg;

	// board geometry
	localparam int board_dim = 8;
	localparam int cell_count = 64;

	// tick periods in clock cycles, scaled for simulation
	localparam int step_cycles = 2048;
	localparam int second_cycles = 4096;
	localparam int scan_cycles = 16;
	localparam int scan_phases = 8;

	// row and column of one board cell
	typedef struct packed {
		logic [2:0] row;
		logic [2:0] col;
	} cell_rc_t;

	// one cell, read flat for the body store and the search stride,
	// or split for movement and drawing
	typedef union packed {
		logic [5:0] idx;
		cell_rc_t rc;
	} cell_t;

	typedef enum logic [1:0] {
		dir_up,
		dir_down,
		dir_left,
		dir_right
	} dir_t;

	typedef enum logic {
		stage_playing,
		stage_over
	} stage_t;

	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
	} dir_keys_t;

	// three packed BCD digits, hundreds at the top
	typedef logic [11:0] bcd3_t;

	// picture handed from the engine to the display
	typedef struct packed {
		logic [cell_count-1:0] occupancy;
		cell_t head;
		cell_t apple;
		stage_t stage;
	} board_t;

	// row 3, column 4
	localparam cell_t apple_start = 6'b011_100;
	// odd, so the walk covers every cell
	localparam logic [5:0] apple_stride = 6'd39;
	localparam logic [7:0] lfsr_seed = 8'hb5;

	// segment a in bit 7, dp in bit 0; listed from 9 down to 0
	localparam logic [9:0][7:0] seg_patterns = {
		8'hf6, 8'hfe, 8'he0, 8'hbe, 8'hb6,
		8'h66, 8'hf2, 8'hda, 8'h60, 8'hfc
	};

endpackage
